// File: rtl/edram_settings.svh
`ifndef EDRAM_SETTINGS_SVH
`define EDRAM_SETTINGS_SVH

// Bits per user word.
`define EDRAM_WIDTH 32

// Words packed side by side in one physical row.
`define EDRAM_NUMWRDS 4

// Physical banks, each with its own memory port.
`define EDRAM_NUMBNK 4

// Rows per bank.
`define EDRAM_NUMROW 64

// Cycles from the edge that samples a memory read to valid mem_dout.
`define EDRAM_MEM_DELAY 2

`endif

// File: rtl/edram_addr_pkg.sv
`default_nettype none

`include "edram_settings.svh"

package edram_addr_pkg;

  typedef logic [$clog2(`EDRAM_NUMWRDS)-1:0] lane_t;
  typedef logic [$clog2(`EDRAM_NUMBNK)-1:0]  bank_t;
  typedef logic [$clog2(`EDRAM_NUMROW)-1:0]  row_t;

  // User word address, lane in the low bits.
  typedef struct packed {
    row_t  row;
    bank_t bank;
    lane_t lane;
  } vaddr_t;

  // Physical address returned with each read.
  typedef struct packed {
    row_t  row;
    bank_t bank;
    lane_t lane;
  } padr_t;

endpackage

`default_nettype wire

// File: rtl/edram_op_pkg.sv
`default_nettype none

`include "edram_settings.svh"

package edram_op_pkg;

  typedef logic [`EDRAM_WIDTH-1:0] word_t;

  // A full physical row, also the shape of the bit-write mask.
  typedef logic [`EDRAM_NUMWRDS*`EDRAM_WIDTH-1:0] phys_t;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_READ,
    CMD_WRITE,
    CMD_REFRESH
  } cmd_e;

endpackage

`default_nettype wire

// File: rtl/edram_req_map.sv
`default_nettype none

`include "edram_settings.svh"

module edram_req_map (
  input  wire logic                                       clk,
  input  wire logic                                       rst,
  input  wire logic                                       refr,
  input  wire logic                                       read,
  input  wire logic                                       write,
  input  wire edram_addr_pkg::vaddr_t                     addr,
  input  wire edram_op_pkg::word_t                        din,
  output logic                                            ready,
  output logic [`EDRAM_NUMBNK-1:0]                        mem_read,
  output logic [`EDRAM_NUMBNK-1:0]                        mem_write,
  output logic [`EDRAM_NUMBNK-1:0]                        mem_refr,
  output edram_addr_pkg::row_t [`EDRAM_NUMBNK-1:0]        mem_addr,
  output edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]         mem_bw,
  output edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]         mem_din,
  output logic                                            trk_vld,
  output edram_addr_pkg::bank_t                           trk_bank,
  output edram_addr_pkg::padr_t                           trk_padr
);

  edram_op_pkg::cmd_e                              acc_cmd;
  edram_op_pkg::cmd_e                              rf_cmd;
  edram_addr_pkg::bank_t                           rf_ptr;
  edram_op_pkg::phys_t                             lane_mask;
  logic [`EDRAM_NUMBNK-1:0]                        nxt_read;
  logic [`EDRAM_NUMBNK-1:0]                        nxt_write;
  logic [`EDRAM_NUMBNK-1:0]                        nxt_refr;
  edram_addr_pkg::row_t [`EDRAM_NUMBNK-1:0]        nxt_addr;
  edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]         nxt_bw;
  edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]         nxt_din;

  // Write beats read, nothing is taken while not ready.
  always_comb begin
    acc_cmd = edram_op_pkg::CMD_IDLE;
    if (ready && write) begin
      acc_cmd = edram_op_pkg::CMD_WRITE;
    end else if (ready && read) begin
      acc_cmd = edram_op_pkg::CMD_READ;
    end
  end

  assign rf_cmd = (ready && refr) ? edram_op_pkg::CMD_REFRESH : edram_op_pkg::CMD_IDLE;

  assign lane_mask = edram_op_pkg::phys_t'({`EDRAM_WIDTH{1'b1}}) << (addr.lane * `EDRAM_WIDTH);

  // Only the addressed bank slot is loaded, the rest stay zero.
  always_comb begin
    nxt_read  = '0;
    nxt_write = '0;
    nxt_addr  = '0;
    nxt_bw    = '0;
    nxt_din   = '0;
    case (acc_cmd)
      edram_op_pkg::CMD_READ: begin
        nxt_read[addr.bank] = 1'b1;
        nxt_addr[addr.bank] = addr.row;
      end
      edram_op_pkg::CMD_WRITE: begin
        nxt_write[addr.bank] = 1'b1;
        nxt_addr[addr.bank]  = addr.row;
        nxt_bw[addr.bank]    = lane_mask;
        nxt_din[addr.bank]   = {`EDRAM_NUMWRDS{din}};
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    nxt_refr = '0;
    if (rf_cmd == edram_op_pkg::CMD_REFRESH) begin
      nxt_refr[rf_ptr] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ready     <= 1'b0;
      mem_read  <= '0;
      mem_write <= '0;
      mem_refr  <= '0;
      rf_ptr    <= '0;
      trk_vld   <= 1'b0;
    end else begin
      ready     <= 1'b1;
      mem_read  <= nxt_read;
      mem_write <= nxt_write;
      mem_refr  <= nxt_refr;
      trk_vld   <= (acc_cmd == edram_op_pkg::CMD_READ);
      // Round robin over the banks.
      if (rf_cmd == edram_op_pkg::CMD_REFRESH) begin
        if (rf_ptr == edram_addr_pkg::bank_t'(`EDRAM_NUMBNK - 1)) begin
          rf_ptr <= '0;
        end else begin
          rf_ptr <= rf_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    mem_addr      <= nxt_addr;
    mem_bw        <= nxt_bw;
    mem_din       <= nxt_din;
    trk_bank      <= addr.bank;
    trk_padr.row  <= addr.row;
    trk_padr.bank <= addr.bank;
    trk_padr.lane <= addr.lane;
  end

endmodule

`default_nettype wire

// File: rtl/edram_rd_track.sv
`default_nettype none

`include "edram_settings.svh"

module edram_rd_track (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   trk_vld,
  input  wire edram_addr_pkg::bank_t  trk_bank,
  input  wire edram_addr_pkg::padr_t  trk_padr,
  output logic                        out_vld,
  output edram_addr_pkg::bank_t       out_bank,
  output edram_addr_pkg::padr_t       out_padr
);

  // Stage 0 lines up with the memory sampling the read,
  // the remaining stages follow the memory delay.
  localparam int DEPTH = `EDRAM_MEM_DELAY + 1;

  logic [DEPTH-1:0]                         vld_q;
  edram_addr_pkg::bank_t [DEPTH-1:0]        bank_q;
  edram_addr_pkg::padr_t [DEPTH-1:0]        padr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[DEPTH-2:0], trk_vld};
    end
  end

  // Tags shift unconditionally, valid bits mark the live ones.
  always_ff @(posedge clk) begin
    bank_q <= {bank_q[DEPTH-2:0], trk_bank};
    padr_q <= {padr_q[DEPTH-2:0], trk_padr};
  end

  assign out_vld  = vld_q[DEPTH-1];
  assign out_bank = bank_q[DEPTH-1];
  assign out_padr = padr_q[DEPTH-1];

endmodule

`default_nettype wire

// File: rtl/edram_rd_align.sv
`default_nettype none

`include "edram_settings.svh"

module edram_rd_align (
  input  wire logic                                      clk,
  input  wire logic                                      rst,
  input  wire logic                                      out_vld,
  input  wire edram_addr_pkg::bank_t                     out_bank,
  input  wire edram_addr_pkg::padr_t                     out_padr,
  input  wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_dout,
  output logic                                           rd_vld,
  output edram_op_pkg::word_t                            rd_dout,
  output edram_addr_pkg::padr_t                          rd_padr
);

  edram_op_pkg::phys_t  row_sel;
  edram_op_pkg::word_t  word_sel;

  // Row from the bank that served the read.
  assign row_sel = mem_dout[out_bank];

  // Lane named in the tag.
  assign word_sel = row_sel[out_padr.lane * `EDRAM_WIDTH +: `EDRAM_WIDTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= out_vld;
    end
  end

  // Data and tag hold their last value between reads.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_dout <= '0;
      rd_padr <= '0;
    end else if (out_vld) begin
      rd_dout <= word_sel;
      rd_padr <= out_padr;
    end
  end

endmodule

`default_nettype wire

// File: rtl/edram_top.sv
`default_nettype none

`include "edram_settings.svh"

module edram_top (
  input  wire logic                                      clk,
  input  wire logic                                      rst,
  input  wire logic                                      refr,
  input  wire logic                                      read,
  input  wire logic                                      write,
  input  wire edram_addr_pkg::vaddr_t                    addr,
  input  wire edram_op_pkg::word_t                       din,
  output wire logic                                      ready,
  output wire logic                                      rd_vld,
  output wire edram_op_pkg::word_t                       rd_dout,
  output wire edram_addr_pkg::padr_t                     rd_padr,
  output wire logic [`EDRAM_NUMBNK-1:0]                  mem_read,
  output wire logic [`EDRAM_NUMBNK-1:0]                  mem_write,
  output wire logic [`EDRAM_NUMBNK-1:0]                  mem_refr,
  output wire edram_addr_pkg::row_t [`EDRAM_NUMBNK-1:0]  mem_addr,
  output wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_bw,
  output wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_din,
  input  wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_dout
);

  // Read tag into the delay pipeline.
  wire logic                    trk_vld;
  wire edram_addr_pkg::bank_t   trk_bank;
  wire edram_addr_pkg::padr_t   trk_padr;

  // Tag out of the pipeline, aligned with mem_dout.
  wire logic                    out_vld;
  wire edram_addr_pkg::bank_t   out_bank;
  wire edram_addr_pkg::padr_t   out_padr;

  edram_req_map u_req_map (
    .clk       (clk),
    .rst       (rst),
    .refr      (refr),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .ready     (ready),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_refr  (mem_refr),
    .mem_addr  (mem_addr),
    .mem_bw    (mem_bw),
    .mem_din   (mem_din),
    .trk_vld   (trk_vld),
    .trk_bank  (trk_bank),
    .trk_padr  (trk_padr)
  );

  edram_rd_track u_rd_track (
    .clk      (clk),
    .rst      (rst),
    .trk_vld  (trk_vld),
    .trk_bank (trk_bank),
    .trk_padr (trk_padr),
    .out_vld  (out_vld),
    .out_bank (out_bank),
    .out_padr (out_padr)
  );

  edram_rd_align u_rd_align (
    .clk      (clk),
    .rst      (rst),
    .out_vld  (out_vld),
    .out_bank (out_bank),
    .out_padr (out_padr),
    .mem_dout (mem_dout),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_padr  (rd_padr)
  );

endmodule

`default_nettype wire

// File: bench/edram_mem_model.sv
`default_nettype none

`include "edram_settings.svh"

module edram_mem_model (
  input  wire logic                                      clk,
  input  wire logic                                      rst,
  input  wire logic [`EDRAM_NUMBNK-1:0]                  mem_read,
  input  wire logic [`EDRAM_NUMBNK-1:0]                  mem_write,
  input  wire logic [`EDRAM_NUMBNK-1:0]                  mem_refr,
  input  wire edram_addr_pkg::row_t [`EDRAM_NUMBNK-1:0]  mem_addr,
  input  wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_bw,
  input  wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_din,
  output wire edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]   mem_dout,
  output logic [`EDRAM_NUMBNK-1:0][15:0]                 refr_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  edram_op_pkg::phys_t                      rows [`EDRAM_NUMBNK][`EDRAM_NUMROW];
  // Stage 0 holds the row read at the sampling edge.
  edram_op_pkg::phys_t [`EDRAM_NUMBNK-1:0]  dly [`EDRAM_MEM_DELAY + 1];

  always @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `EDRAM_NUMBNK; b++) begin
        for (int r = 0; r < `EDRAM_NUMROW; r++) begin
          rows[b][r] <= '0;
        end
      end
      for (int s = 0; s <= `EDRAM_MEM_DELAY; s++) begin
        dly[s] <= '0;
      end
      refr_cnt <= '0;
    end else begin
      for (int b = 0; b < `EDRAM_NUMBNK; b++) begin
        // Only the bits set in the mask change.
        if (mem_write[b]) begin
          rows[b][mem_addr[b]] <= (rows[b][mem_addr[b]] & ~mem_bw[b]) |
                                  (mem_din[b] & mem_bw[b]);
        end
        if (mem_read[b]) begin
          dly[0][b] <= rows[b][mem_addr[b]];
        end else begin
          dly[0][b] <= 'x;
        end
        if (mem_refr[b]) begin
          refr_cnt[b] <= refr_cnt[b] + 1'b1;
        end
      end
      for (int s = 1; s <= `EDRAM_MEM_DELAY; s++) begin
        dly[s] <= dly[s-1];
      end
    end
  end

  assign mem_dout = dly[`EDRAM_MEM_DELAY];

endmodule

`default_nettype wire

// File: bench/edram_tb.sv
`default_nettype none

`include "edram_settings.svh"

module edram_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NB = `EDRAM_NUMBNK;
  localparam int NW = `EDRAM_NUMWRDS;
  localparam int NWORDS = NB * NW * `EDRAM_NUMROW;
  // Request register, memory delay, then the aligner register.
  localparam int READ_LAT = `EDRAM_MEM_DELAY + 2;
  localparam int N_WR = 6;
  localparam int N_B2B = 8;
  localparam int N_RF = 5;
  localparam int TOTAL_REQ = 2 + 2 * N_WR + 2 * NW * NB + 2 * N_B2B + 2 + 2 * N_RF;
  localparam int CYCLE_LIMIT = TOTAL_REQ * (READ_LAT + 2) + 100;

  logic                           clk = 1'b0;
  logic                           rst;
  logic                           refr;
  logic                           read;
  logic                           write;
  edram_addr_pkg::vaddr_t         addr;
  edram_op_pkg::word_t            din;
  logic                           ready;
  logic                           rd_vld;
  edram_op_pkg::word_t            rd_dout;
  edram_addr_pkg::padr_t          rd_padr;
  logic [NB-1:0]                  mem_read;
  logic [NB-1:0]                  mem_write;
  logic [NB-1:0]                  mem_refr;
  edram_addr_pkg::row_t [NB-1:0]  mem_addr;
  edram_op_pkg::phys_t [NB-1:0]   mem_bw;
  edram_op_pkg::phys_t [NB-1:0]   mem_din;
  edram_op_pkg::phys_t [NB-1:0]   mem_dout;
  logic [NB-1:0][15:0]            refr_cnt;

  // Reference contents, indexed by the user word address.
  edram_op_pkg::word_t            shadow [NWORDS];
  int                             exp_due [$];
  edram_op_pkg::word_t            exp_data [$];
  edram_addr_pkg::padr_t          exp_padr [$];
  edram_op_pkg::word_t            held_dout = '0;
  edram_addr_pkg::padr_t          held_padr = '0;
  int                             rf_due [$];
  int                             rf_bank = 0;
  int                             rf_issued = 0;
  int                             ncyc = 0;
  int                             errors = 0;
  logic [31:0]                    lfsr = 32'hdbec;
  string                          cur_test = "init";

  edram_top UUT (
    .clk       (clk),
    .rst       (rst),
    .refr      (refr),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .ready     (ready),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_refr  (mem_refr),
    .mem_addr  (mem_addr),
    .mem_bw    (mem_bw),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout)
  );

  edram_mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_refr  (mem_refr),
    .mem_addr  (mem_addr),
    .mem_bw    (mem_bw),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout),
    .refr_cnt  (refr_cnt)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR, taps 32, 22, 2, 1.
  function automatic logic [31:0] next_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic edram_op_pkg::word_t rand_word();
    return next_bits(`EDRAM_WIDTH);
  endfunction

  function automatic edram_addr_pkg::vaddr_t rand_addr();
    logic [31:0] v;
    v = next_bits($bits(edram_addr_pkg::vaddr_t));
    return v[$bits(edram_addr_pkg::vaddr_t)-1:0];
  endfunction

  task automatic check_eq(string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_fail(string msg);
    errors++;
    $display("[ERROR] %s: %s", cur_test, msg);
  endtask

  // One request for one cycle, with the expected results queued.
  task automatic drive(logic rd, logic wr, logic rf, edram_addr_pkg::vaddr_t a,
                       edram_op_pkg::word_t d);
    edram_op_pkg::cmd_e cmd;
    cmd = edram_op_pkg::CMD_IDLE;
    if (wr) begin
      cmd = edram_op_pkg::CMD_WRITE;
    end else if (rd) begin
      cmd = edram_op_pkg::CMD_READ;
    end
    @(posedge clk);
    read  <= rd;
    write <= wr;
    refr  <= rf;
    addr  <= a;
    din   <= d;
    if (cmd == edram_op_pkg::CMD_WRITE) begin
      shadow[a] = d;
    end
    // Monitor counts negedges, the DUT samples one edge later.
    if (cmd == edram_op_pkg::CMD_READ) begin
      exp_due.push_back(ncyc + 2 + READ_LAT);
      exp_data.push_back(shadow[a]);
      exp_padr.push_back({a.row, a.bank, a.lane});
    end
    if (rf) begin
      rf_due.push_back(ncyc + 2);
      rf_issued++;
    end
  endtask

  task automatic release_bus();
    @(posedge clk);
    read  <= 1'b0;
    write <= 1'b0;
    refr  <= 1'b0;
  endtask

  task automatic wait_done();
    while (exp_due.size() != 0 || rf_due.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic test_reset();
    edram_addr_pkg::vaddr_t a;
    cur_test = "reset";
    a = rand_addr();
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      // Requests applied while the DUT is held in reset.
      if (i == 0) begin
        write <= 1'b1;
        read  <= 1'b1;
        refr  <= 1'b1;
        addr  <= a;
        din   <= rand_word() | 32'h1;
      end
      if (i == 2) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_eq("ready", 1'b0, ready);
      check_eq("rd_vld", 1'b0, rd_vld);
      check_eq("memory strobes", '0, {mem_read, mem_write, mem_refr});
    end
    // The first edge out of reset still sees ready low.
    @(posedge clk);
    write <= 1'b0;
    read  <= 1'b0;
    refr  <= 1'b0;
    @(negedge clk);
    check_eq("ready", 1'b1, ready);
    check_eq("memory strobes", '0, {mem_read, mem_write, mem_refr});
    drive(1'b1, 1'b0, 1'b0, a, '0);
    release_bus();
    wait_done();
  endtask

  task automatic test_write_read();
    edram_addr_pkg::vaddr_t a;
    cur_test = "write_read";
    for (int i = 0; i < N_WR; i++) begin
      a = rand_addr();
      drive(1'b0, 1'b1, 1'b0, a, rand_word());
      drive(1'b1, 1'b0, 1'b0, a, '0);
      release_bus();
      wait_done();
    end
  endtask

  task automatic test_lane_mask();
    edram_addr_pkg::vaddr_t a;
    logic [31:0] r;
    cur_test = "lane_mask";
    for (int b = 0; b < NB; b++) begin
      a = rand_addr();
      a.bank = edram_addr_pkg::bank_t'(b);
      for (int l = 0; l < NW; l++) begin
        a.lane = edram_addr_pkg::lane_t'(l);
        r = next_bits(30);
        drive(1'b0, 1'b1, 1'b0, a, {r[29:0], 2'(l)});
      end
      for (int l = 0; l < NW; l++) begin
        a.lane = edram_addr_pkg::lane_t'(l);
        drive(1'b1, 1'b0, 1'b0, a, '0);
      end
      release_bus();
      wait_done();
    end
  endtask

  task automatic test_back_to_back();
    edram_addr_pkg::vaddr_t a [N_B2B];
    cur_test = "back_to_back";
    for (int i = 0; i < N_B2B; i++) begin
      a[i] = rand_addr();
      a[i].bank = edram_addr_pkg::bank_t'(i % NB);
      drive(1'b0, 1'b1, 1'b0, a[i], rand_word());
    end
    for (int i = 0; i < N_B2B; i++) begin
      drive(1'b1, 1'b0, 1'b0, a[i], '0);
    end
    release_bus();
    wait_done();
  endtask

  task automatic test_conflict();
    edram_addr_pkg::vaddr_t a;
    cur_test = "conflict";
    a = rand_addr();
    drive(1'b1, 1'b1, 1'b0, a, rand_word());
    drive(1'b1, 1'b0, 1'b0, a, '0);
    release_bus();
    wait_done();
  endtask

  task automatic test_refresh();
    edram_addr_pkg::vaddr_t a [N_RF];
    cur_test = "refresh";
    for (int i = 0; i < N_RF; i++) begin
      a[i] = rand_addr();
      drive(1'b0, 1'b1, 1'b1, a[i], rand_word());
    end
    for (int i = 0; i < N_RF; i++) begin
      drive(1'b1, 1'b0, (i % 2 == 0), a[i], '0);
    end
    release_bus();
    wait_done();
  endtask

  // Outputs are checked at the falling edge, away from the DUT updates.
  always @(negedge clk) begin
    ncyc = ncyc + 1;
    assert ($countones(mem_read | mem_write) <= 1)
      else report_fail("more than one bank accessed in one cycle");
    // Banks without an access carry zero on every slot.
    for (int b = 0; b < NB; b++) begin
      assert (mem_read[b] || mem_write[b] ||
              (mem_addr[b] === '0 && mem_bw[b] === '0 && mem_din[b] === '0))
        else report_fail($sformatf("idle bank %0d slot is not zero", b));
    end
    assert (!(rd_vld && exp_due.size() == 0))
      else report_fail("rd_vld rose with no read outstanding");
    if (rd_vld && exp_due.size() > 0) begin
      held_dout = exp_data.pop_front();
      held_padr = exp_padr.pop_front();
      check_eq("rd_vld cycle", exp_due.pop_front(), ncyc);
      check_eq("rd_dout", held_dout, rd_dout);
      check_eq("rd_padr", held_padr, rd_padr);
    end else if (!rd_vld) begin
      // Between reads the outputs keep the last result.
      check_eq("rd_dout hold", held_dout, rd_dout);
      check_eq("rd_padr hold", held_padr, rd_padr);
    end
    assert (rd_vld || exp_due.size() == 0 || ncyc <= exp_due[0]) else begin
      report_fail("a read result never arrived");
      void'(exp_due.pop_front());
      void'(exp_data.pop_front());
      void'(exp_padr.pop_front());
    end
    if (mem_refr != '0) begin
      check_eq("mem_refr", 64'(1) << rf_bank, mem_refr);
      assert (rf_due.size() > 0) else report_fail("refresh pulse without a refr request");
      if (rf_due.size() > 0) begin
        check_eq("mem_refr cycle", rf_due.pop_front(), ncyc);
      end
      rf_bank = (rf_bank + 1) % NB;
    end
    assert (mem_refr != '0 || rf_due.size() == 0 || ncyc < rf_due[0]) else begin
      report_fail("a refresh pulse never appeared");
      void'(rf_due.pop_front());
    end
  end

  initial begin
    while (ncyc < CYCLE_LIMIT) begin
      @(posedge clk);
    end
    $display("Timeout after %0d cycles, %0d reads outstanding", ncyc, exp_due.size());
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int exp_cnt;
    rst   = 1'b1;
    refr  = 1'b0;
    read  = 1'b0;
    write = 1'b0;
    addr  = '0;
    din   = '0;
    for (int i = 0; i < NWORDS; i++) begin
      shadow[i] = '0;
    end
    test_reset();
    test_write_read();
    test_lane_mask();
    test_back_to_back();
    test_conflict();
    test_refresh();
    cur_test = "refresh_count";
    for (int b = 0; b < NB; b++) begin
      exp_cnt = rf_issued / NB + ((b < rf_issued % NB) ? 1 : 0);
      check_eq("pulses per bank", exp_cnt, refr_cnt[b]);
    end
    $display("Run finished after %0d cycles with %0d errors", ncyc, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/edram_addr_pkg.sv
rtl/edram_op_pkg.sv
rtl/edram_req_map.sv
rtl/edram_rd_track.sv
rtl/edram_rd_align.sv
rtl/edram_top.sv
bench/edram_mem_model.sv
bench/edram_tb.sv

// File: Bender.yml
package:
  name: edram_frontend

sources:
  - target: rtl
    include_dirs:
      - rtl
    files:
      - rtl/edram_addr_pkg.sv
      - rtl/edram_op_pkg.sv
      - rtl/edram_req_map.sv
      - rtl/edram_rd_track.sv
      - rtl/edram_rd_align.sv
      - rtl/edram_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/edram_mem_model.sv
      - bench/edram_tb.sv
